/* hdl/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ============================================================
// rename stage sizing
// ============================================================

// architectural register file
`define RN_ARCH_REGS      32
// physical register file
`define RN_PHYS_REGS      64
// instructions renamed per group
`define RN_DISPATCH_WIDTH 2
// registers released by commit per cycle
`define RN_COMMIT_WIDTH   2
// branch checkpoints in flight
`define RN_CHECKPOINTS    4
// free queue holds every register not mapped at reset
`define RN_FREE_DEPTH     (`RN_PHYS_REGS - `RN_ARCH_REGS)

`endif

/* hdl/rename_pkg.sv */
`include "rename_defines.svh"

package rename_pkg;

    // ============================================================
    // register and pointer types
    // ============================================================

    typedef logic [$clog2(`RN_ARCH_REGS)-1:0]    arch_t;
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0]    phys_t;
    // free queue pointer, msb is the wrap bit
    typedef logic [$clog2(`RN_FREE_DEPTH):0]     fl_ptr_t;
    // 0 up to RN_FREE_DEPTH inclusive
    typedef logic [$clog2(`RN_FREE_DEPTH+1)-1:0] fl_count_t;
    typedef logic [$clog2(`RN_CHECKPOINTS)-1:0]  ckpt_tag_t;
    // whole map, indexed by arch register
    typedef phys_t [`RN_ARCH_REGS-1:0]           map_t;

    // ============================================================
    // dispatch side
    // ============================================================

    typedef struct packed {
        logic  has_dest;
        arch_t dest;
        arch_t src1;
        arch_t src2;
    } rename_slot_t;

    // slot 0 is the oldest, a branch is always the youngest slot
    typedef struct packed {
        logic                                   valid;
        logic                                   is_branch;
        rename_slot_t [`RN_DISPATCH_WIDTH-1:0] slots;
    } rename_group_t;

    // ============================================================
    // result, commit and resolve
    // ============================================================

    typedef struct packed {
        logic  has_dest;
        phys_t phys_dest;
        phys_t old_phys;
        phys_t phys_src1;
        phys_t phys_src2;
    } slot_result_t;

    typedef struct packed {
        logic                                   valid;
        logic                                   is_branch;
        ckpt_tag_t                              tag;
        slot_result_t [`RN_DISPATCH_WIDTH-1:0] slots;
    } rename_result_t;

    // one lane per released register
    typedef struct packed {
        logic  [`RN_COMMIT_WIDTH-1:0] valid;
        phys_t [`RN_COMMIT_WIDTH-1:0] phys;
    } commit_t;

    typedef struct packed {
        logic      valid;
        logic      mispredict;
        ckpt_tag_t tag;
    } branch_resolve_t;

endpackage

/* hdl/free_list.sv */
`timescale 1ns/1ps
`include "rename_defines.svh"

module free_list import rename_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    // allocate side, one request per dispatch slot
    input  logic  [`RN_DISPATCH_WIDTH-1:0]      alloc_req_i,
    output phys_t [`RN_DISPATCH_WIDTH-1:0]      alloc_phys_o,
    // release side from commit
    input  commit_t                             commit_i,
    // mispredict recovery
    input  logic                                restore_i,
    input  fl_ptr_t                             restore_head_i,
    output fl_ptr_t                             head_next_o,
    output fl_count_t                           free_count_o
);

    localparam int IDX_W = $clog2(`RN_FREE_DEPTH);

    // circular queue storage
    phys_t     free_fifo [`RN_FREE_DEPTH];
    // storage with this cycle's releases merged in
    phys_t     fifo_view [`RN_FREE_DEPTH];

    fl_ptr_t   head_q;
    fl_ptr_t   tail_q;
    fl_count_t count_q;

    fl_ptr_t   head_next;
    fl_ptr_t   tail_next;
    fl_count_t count_next;
    fl_count_t n_alloc;
    fl_count_t n_free;
    // write pointer of each commit lane
    fl_ptr_t   rel_ptr [`RN_COMMIT_WIDTH];

    // ============================================================
    // release first
    // ============================================================

    // valid lanes are packed at the tail in lane order
    always_comb begin
        tail_next = tail_q;
        n_free    = '0;
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            rel_ptr[j] = tail_next;
            if (commit_i.valid[j]) begin
                tail_next = tail_next + 1'b1;
                n_free    = n_free + 1'b1;
            end
        end
    end

    // released tags visible to the allocator this cycle
    always_comb begin
        fifo_view = free_fifo;
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            if (commit_i.valid[j]) begin
                fifo_view[rel_ptr[j][IDX_W-1:0]] = commit_i.phys[j];
            end
        end
    end

    // ============================================================
    // allocate from the head in slot order
    // ============================================================

    always_comb begin
        head_next = head_q;
        n_alloc   = '0;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            // slot sees the entry after all older requests
            alloc_phys_o[i] = fifo_view[head_next[IDX_W-1:0]];
            if (alloc_req_i[i]) begin
                head_next = head_next + 1'b1;
                n_alloc   = n_alloc + 1'b1;
            end
        end
    end

    // on restore the count comes back from the pointers,
    // so releases made since the checkpoint stay free
    always_comb begin
        if (restore_i) begin
            count_next = fl_count_t'(tail_next - restore_head_i);
        end else begin
            count_next = count_q + n_free - n_alloc;
        end
    end

    // ============================================================
    // state
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            // queue starts full
            tail_q  <= fl_ptr_t'(`RN_FREE_DEPTH);
            count_q <= fl_count_t'(`RN_FREE_DEPTH);
        end else begin
            head_q  <= restore_i ? restore_head_i : head_next;
            tail_q  <= tail_next;
            count_q <= count_next;
        end
    end

    // initial contents RN_ARCH_REGS upward
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `RN_FREE_DEPTH; k++) begin
                free_fifo[k] <= phys_t'(`RN_ARCH_REGS + k);
            end
        end else begin
            for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
                if (commit_i.valid[j]) begin
                    free_fifo[rel_ptr[j][IDX_W-1:0]] <= commit_i.phys[j];
                end
            end
        end
    end

    // head after this cycle's allocations, for the checkpoint
    assign head_next_o  = head_next;
    assign free_count_o = count_q;

endmodule

/* hdl/map_table.sv */
`timescale 1ns/1ps
`include "rename_defines.svh"

module map_table import rename_pkg::*; (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    accept_i,
    input  rename_group_t                           group_i,
    // new tags from the free list, one per slot
    input  phys_t        [`RN_DISPATCH_WIDTH-1:0]   alloc_phys_i,
    // full reload on mispredict
    input  logic                                    restore_i,
    input  map_t                                    restore_map_i,
    output slot_result_t [`RN_DISPATCH_WIDTH-1:0]   result_slots_o,
    output map_t                                    map_next_o
);

    // committed plus speculative mapping
    map_t map_q;
    // map after every slot of the group has written
    map_t spec_map;

    // ============================================================
    // lookup with in-group bypass
    // ============================================================

    // walking the slots oldest first and writing as we go gives
    // each slot the older slots' destinations for free
    always_comb begin
        rename_slot_t slot;
        spec_map = map_q;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            slot = group_i.slots[i];
            result_slots_o[i].has_dest  = slot.has_dest;
            // sources read before this slot's own write
            result_slots_o[i].phys_src1 = spec_map[slot.src1];
            result_slots_o[i].phys_src2 = spec_map[slot.src2];
            if (slot.has_dest) begin
                result_slots_o[i].phys_dest = alloc_phys_i[i];
                // old mapping goes to the ROB for later release
                result_slots_o[i].old_phys  = spec_map[slot.dest];
                spec_map[slot.dest]         = alloc_phys_i[i];
            end else begin
                result_slots_o[i].phys_dest = '0;
                result_slots_o[i].old_phys  = '0;
            end
        end
    end

    // youngest write wins, nothing changes without accept
    assign map_next_o = accept_i ? spec_map : map_q;

    // ============================================================
    // table update
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity map
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                map_q[a] <= phys_t'(a);
            end
        end else if (restore_i) begin
            map_q <= restore_map_i;
        end else begin
            map_q <= map_next_o;
        end
    end

endmodule

/* hdl/checkpoint_bank.sv */
`timescale 1ns/1ps
`include "rename_defines.svh"

module checkpoint_bank import rename_pkg::*; #(
    // snapshot type, map or free-list head
    parameter type payload_t = logic
) (
    input  logic      clock,
    input  logic      reset,
    // write on an accepted branch group
    input  logic      write_i,
    input  ckpt_tag_t write_tag_i,
    input  payload_t  data_i,
    // read at the resolving tag
    input  ckpt_tag_t read_tag_i,
    output payload_t  data_o
);

    // one snapshot per branch tag
    payload_t bank_q [`RN_CHECKPOINTS];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `RN_CHECKPOINTS; k++) begin
                bank_q[k] <= '0;
            end
        end else if (write_i) begin
            bank_q[write_tag_i] <= data_i;
        end
    end

    // asynchronous read
    // no write can hit the read tag during a restore, stall is high
    assign data_o = bank_q[read_tag_i];

endmodule

/* hdl/branch_tag_alloc.sv */
`timescale 1ns/1ps
`include "rename_defines.svh"

module branch_tag_alloc import rename_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    // accepted branch group
    input  logic            alloc_i,
    input  branch_resolve_t resolve_i,
    output ckpt_tag_t       alloc_tag_o,
    output logic            full_o,
    // one-cycle restore request for map and free list
    output logic            restore_o,
    output ckpt_tag_t       restore_tag_o
);

    localparam int CNT_W = $clog2(`RN_CHECKPOINTS) + 1;

    ckpt_tag_t       next_q;
    // tags in flight
    logic [CNT_W-1:0] count_q;
    // resolve held one cycle, stall is then taken from it
    branch_resolve_t resolve_q;

    logic retire;
    logic squash;

    assign retire = resolve_q.valid & ~resolve_q.mispredict;
    assign squash = resolve_q.valid & resolve_q.mispredict;

    // ============================================================
    // tag pointers
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            next_q    <= '0;
            count_q   <= '0;
            resolve_q <= '0;
        end else begin
            resolve_q <= resolve_i;
            if (squash) begin
                // resolved tag is oldest, everything younger dies
                // and the mispredicted branch itself is done
                next_q   <= resolve_q.tag + 1'b1;
                count_q  <= '0;
            end else begin
                if (alloc_i) begin
                    next_q <= next_q + 1'b1;
                end
                // in-order retire of the oldest checkpoint
                count_q <= count_q + CNT_W'(alloc_i) - CNT_W'(retire);
            end
        end
    end

    assign alloc_tag_o   = next_q;
    assign full_o        = (count_q == CNT_W'(`RN_CHECKPOINTS));
    assign restore_o     = squash;
    assign restore_tag_o = resolve_q.tag;

endmodule

/* hdl/rename_stage.sv */
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_stage import rename_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  rename_group_t   group_i,
    input  commit_t         commit_i,
    input  branch_resolve_t resolve_i,
    output rename_result_t  result_o,
    output logic            stall_o,
    output fl_count_t       free_count_o
);

    logic                                   accept;
    logic                                   ckpt_write;
    logic                                   tags_full;
    logic                                   restore;
    logic         [`RN_DISPATCH_WIDTH-1:0]  alloc_req;
    phys_t        [`RN_DISPATCH_WIDTH-1:0]  alloc_phys;
    slot_result_t [`RN_DISPATCH_WIDTH-1:0]  slots;
    fl_ptr_t                                head_next;
    fl_ptr_t                                restore_head;
    map_t                                   map_next;
    map_t                                   restore_map;
    ckpt_tag_t                              alloc_tag;
    ckpt_tag_t                              restore_tag;
    fl_count_t                              free_count;

    // registered response
    logic                                   result_valid_q;
    logic                                   is_branch_q;
    ckpt_tag_t                              tag_q;
    slot_result_t [`RN_DISPATCH_WIDTH-1:0]  slots_q;

    // ============================================================
    // accept and stall
    // ============================================================

    // all terms registered, a full group always fits
    assign stall_o = (free_count < fl_count_t'(`RN_DISPATCH_WIDTH)) | tags_full | restore;
    assign accept  = group_i.valid & ~stall_o;
    // branch is the youngest slot, so snapshot the post-group state
    assign ckpt_write = accept & group_i.is_branch;

    always_comb begin
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            alloc_req[i] = accept & group_i.slots[i].has_dest;
        end
    end

    // ============================================================
    // blocks
    // ============================================================

    free_list free_list_i (
        .clock          (clock),
        .reset          (reset),
        .alloc_req_i    (alloc_req),
        .alloc_phys_o   (alloc_phys),
        .commit_i       (commit_i),
        .restore_i      (restore),
        .restore_head_i (restore_head),
        .head_next_o    (head_next),
        .free_count_o   (free_count)
    );

    map_table map_table_i (
        .clock          (clock),
        .reset          (reset),
        .accept_i       (accept),
        .group_i        (group_i),
        .alloc_phys_i   (alloc_phys),
        .restore_i      (restore),
        .restore_map_i  (restore_map),
        .result_slots_o (slots),
        .map_next_o     (map_next)
    );

    branch_tag_alloc branch_tag_alloc_i (
        .clock         (clock),
        .reset         (reset),
        .alloc_i       (ckpt_write),
        .resolve_i     (resolve_i),
        .alloc_tag_o   (alloc_tag),
        .full_o        (tags_full),
        .restore_o     (restore),
        .restore_tag_o (restore_tag)
    );

    // map snapshot
    checkpoint_bank #(.payload_t(map_t)) map_bank_i (
        .clock       (clock),
        .reset       (reset),
        .write_i     (ckpt_write),
        .write_tag_i (alloc_tag),
        .data_i      (map_next),
        .read_tag_i  (restore_tag),
        .data_o      (restore_map)
    );

    // free-list head snapshot only, tail is never rolled back
    checkpoint_bank #(.payload_t(fl_ptr_t)) head_bank_i (
        .clock       (clock),
        .reset       (reset),
        .write_i     (ckpt_write),
        .write_tag_i (alloc_tag),
        .data_i      (head_next),
        .read_tag_i  (restore_tag),
        .data_o      (restore_head)
    );

    // ============================================================
    // response register
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= accept;
        end
    end

    // payload held until the next accepted group
    always_ff @(posedge clock) begin
        if (accept) begin
            is_branch_q <= group_i.is_branch;
            tag_q       <= alloc_tag;
            slots_q     <= slots;
        end
    end

    always_comb begin
        result_o.valid     = result_valid_q;
        result_o.is_branch = is_branch_q;
        result_o.tag       = tag_q;
        result_o.slots     = slots_q;
    end

    assign free_count_o = free_count;

endmodule

/* sim/rename_stage_tb.sv */
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_stage_tb import rename_pkg::*; ();

    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int SEED        = 42886;
    localparam int RAND_CYCLES = 400;
    // directed tests stay well below 150 cycles
    localparam int STIM_CYCLES = 150 + RAND_CYCLES;

    // model checkpoint record
    typedef struct packed {
        map_t      map;
        int        head;
        int        seq;
        ckpt_tag_t tag;
    } ckpt_entry_t;

    logic            clock = 1'b0;
    logic            reset;
    rename_group_t   group;
    commit_t         commit;
    branch_resolve_t resolve;
    rename_result_t  result;
    logic            stall;
    fl_count_t       free_count;

    // ============================================================
    // reference model state
    // ============================================================

    map_t            model_map;
    // every tag ever queued, head walks forward
    phys_t           fl_hist [$];
    int              model_head;
    ckpt_tag_t       model_next_tag;
    ckpt_entry_t     ckpt_q [$];
    int              branch_seq;
    logic            squash_pend;
    logic            retire_pend;
    // old tags safe to release, and those still behind a branch
    phys_t           free_ok [$];
    phys_t           spec_phys [$];
    int              spec_dep [$];

    // expected responses and the cycle they are due
    rename_result_t  exp_q [$];
    int              due_q [$];
    rename_result_t  chk_exp;
    int              cycle = 0;
    int              errors = 0;
    int              checks = 0;
    int              errors_at_start = 0;
    int              tests_run = 0;
    int              tests_failed = 0;

    rename_stage rename_stage_i (
        .clock        (clock),
        .reset        (reset),
        .group_i      (group),
        .commit_i     (commit),
        .resolve_i    (resolve),
        .result_o     (result),
        .stall_o      (stall),
        .free_count_o (free_count)
    );

    always #CLK_HALF clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic log_mismatch(input string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        errors++;
    endtask

    // ============================================================
    // model helpers
    // ============================================================

    function automatic int free_cnt();
        return fl_hist.size() - model_head;
    endfunction

    // expected response, sources see older slots of the group
    function automatic rename_result_t predict_group(input rename_group_t g);
        rename_result_t r;
        rename_slot_t   s;
        map_t           m;
        int             h;
        r = '0;
        m = model_map;
        h = model_head;
        r.valid     = 1'b1;
        r.is_branch = g.is_branch;
        r.tag       = model_next_tag;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            s = g.slots[i];
            r.slots[i].has_dest  = s.has_dest;
            r.slots[i].phys_src1 = m[s.src1];
            r.slots[i].phys_src2 = m[s.src2];
            if (s.has_dest) begin
                r.slots[i].phys_dest = fl_hist[h];
                r.slots[i].old_phys  = m[s.dest];
                m[s.dest] = fl_hist[h];
                h++;
            end
        end
        return r;
    endfunction

    task automatic apply_group(input rename_group_t g, input rename_result_t r);
        int          dep;
        ckpt_entry_t e;
        // youngest branch this group depends on, -1 if none
        dep = (ckpt_q.size() > 0) ? ckpt_q[ckpt_q.size()-1].seq : -1;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            if (r.slots[i].has_dest) begin
                model_map[g.slots[i].dest] = r.slots[i].phys_dest;
                model_head++;
                if (dep < 0) begin
                    free_ok.push_back(r.slots[i].old_phys);
                end else begin
                    spec_phys.push_back(r.slots[i].old_phys);
                    spec_dep.push_back(dep);
                end
            end
        end
        // snapshot after the whole group
        if (g.is_branch) begin
            e.map  = model_map;
            e.head = model_head;
            e.seq  = branch_seq;
            e.tag  = model_next_tag;
            ckpt_q.push_back(e);
            branch_seq++;
            model_next_tag = model_next_tag + 1'b1;
        end
    endtask

    // oldest branch mispredicted, younger work is gone
    task automatic restore_model();
        model_map      = ckpt_q[0].map;
        model_head     = ckpt_q[0].head;
        model_next_tag = ckpt_q[0].tag + 1'b1;
        ckpt_q.delete();
        spec_phys.delete();
        spec_dep.delete();
    endtask

    task automatic retire_model();
        int seq;
        seq = ckpt_q[0].seq;
        void'(ckpt_q.pop_front());
        while (spec_dep.size() > 0 && spec_dep[0] <= seq) begin
            free_ok.push_back(spec_phys.pop_front());
            void'(spec_dep.pop_front());
        end
    endtask

    // ============================================================
    // stimulus helpers
    // ============================================================

    function automatic rename_slot_t mk_slot(input logic hd, input int d,
                                             input int s1, input int s2);
        rename_slot_t s;
        s.has_dest = hd;
        s.dest     = arch_t'(d);
        s.src1     = arch_t'(s1);
        s.src2     = arch_t'(s2);
        return s;
    endfunction

    function automatic rename_group_t mk_group(input logic br, input rename_slot_t s0,
                                               input rename_slot_t s1);
        rename_group_t g;
        g.valid     = 1'b1;
        g.is_branch = br;
        g.slots[0]  = s0;
        g.slots[1]  = s1;
        return g;
    endfunction

    function automatic rename_group_t rand_group(input logic br, input logic all_dest);
        rename_group_t g;
        g = '0;
        g.valid     = 1'b1;
        g.is_branch = br;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            g.slots[i].has_dest = all_dest || ($urandom_range(3, 0) != 0);
            g.slots[i].dest     = arch_t'($urandom_range(`RN_ARCH_REGS-1, 0));
            g.slots[i].src1     = arch_t'($urandom_range(`RN_ARCH_REGS-1, 0));
            g.slots[i].src2     = arch_t'($urandom_range(`RN_ARCH_REGS-1, 0));
        end
        return g;
    endfunction

    // up to n releases of non-speculative old tags
    function automatic commit_t take_commits(input int n);
        commit_t c;
        c = '0;
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            if (j < n && free_ok.size() > 0) begin
                c.valid[j] = 1'b1;
                c.phys[j]  = free_ok.pop_front();
            end
        end
        return c;
    endfunction

    // resolve always targets the oldest checkpoint
    function automatic branch_resolve_t mk_resolve(input logic mis);
        branch_resolve_t r;
        r.valid      = 1'b1;
        r.mispredict = mis;
        r.tag        = ckpt_q[0].tag;
        return r;
    endfunction

    // one clock of stimulus plus the model update for its edge
    task automatic step(input rename_group_t g, input commit_t c,
                        input branch_resolve_t r);
        logic           exp_stall;
        rename_result_t exp;
        @(posedge clock);
        #DRIVE_DLY;
        exp_stall = (free_cnt() < `RN_DISPATCH_WIDTH) ||
                    (ckpt_q.size() == `RN_CHECKPOINTS) || squash_pend;
        checks += 2;
        assert (stall === exp_stall) else begin
            log_mismatch($sformatf("stall_o %b, expected %b", stall, exp_stall));
        end
        assert (free_count === fl_count_t'(free_cnt())) else begin
            log_mismatch($sformatf("free_count_o %0d, expected %0d", free_count, free_cnt()));
        end
        group   = g;
        commit  = c;
        resolve = r;
        // release first
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            if (c.valid[j]) begin
                fl_hist.push_back(c.phys[j]);
            end
        end
        exp = '0;
        if (g.valid && !exp_stall) begin
            exp = predict_group(g);
            apply_group(g, exp);
        end
        if (squash_pend) begin
            restore_model();
        end else if (retire_pend) begin
            retire_model();
        end
        squash_pend = r.valid & r.mispredict;
        retire_pend = r.valid & ~r.mispredict;
        exp_q.push_back(exp);
        due_q.push_back(cycle + 1);
    endtask

    task automatic finish_test(input string name);
        int errs;
        step('0, '0, '0);
        @(negedge clock);
        #1;
        errs = errors - errors_at_start;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "FAILED", errs);
        errors_at_start = errors;
    endtask

    // ============================================================
    // response checker
    // ============================================================

    always @(negedge clock) begin
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            chk_exp = exp_q.pop_front();
            void'(due_q.pop_front());
            checks++;
            if (chk_exp.valid) begin
                assert (result === chk_exp) else begin
                    log_mismatch($sformatf("result %h, expected %h", result, chk_exp));
                end
            end else begin
                assert (result.valid === 1'b0) else begin
                    log_mismatch("result valid high without an accepted group");
                end
            end
        end
    end

    // watchdog
    initial begin
        #(STIM_CYCLES * 2 * CLK_HALF + 50 * 2 * CLK_HALF);
        $display("timeout: the run did not reach its end in time");
        $display("Some tests failed");
        $finish;
    end

    // ============================================================
    // tests
    // ============================================================

    initial begin
        rename_group_t   g;
        branch_resolve_t r;
        void'($urandom(SEED));
        reset   = 1'b1;
        group   = '0;
        commit  = '0;
        resolve = '0;
        // reset state, identity map and queue RN_ARCH_REGS upward
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            model_map[a] = phys_t'(a);
        end
        for (int k = 0; k < `RN_FREE_DEPTH; k++) begin
            fl_hist.push_back(phys_t'(`RN_ARCH_REGS + k));
        end
        model_head     = 0;
        model_next_tag = '0;
        branch_seq     = 0;
        squash_pend    = 1'b0;
        retire_pend    = 1'b0;
        repeat (5) @(posedge clock);
        #DRIVE_DLY;
        reset = 1'b0;

        // 1: fresh tags and identity lookups
        step('0, '0, '0);
        step(mk_group(1'b0, mk_slot(1'b1, 3, 1, 2), mk_slot(1'b1, 4, 5, 6)), '0, '0);
        step(mk_group(1'b0, mk_slot(1'b1, 10, 3, 4), mk_slot(1'b0, 0, 31, 0)), '0, '0);
        finish_test("reset and identity");

        // 2: slot 1 sees slot 0's new tag
        step(mk_group(1'b0, mk_slot(1'b1, 7, 7, 8), mk_slot(1'b1, 7, 7, 7)), '0, '0);
        step(mk_group(1'b0, mk_slot(1'b1, 9, 1, 1), mk_slot(1'b0, 0, 9, 9)), '0, '0);
        finish_test("group bypass");

        // 3: head runs past the initial queue into released tags
        for (int k = 0; k < 24; k++) begin
            step(rand_group(1'b0, 1'b1), take_commits(2), '0);
        end
        finish_test("commit release order");

        // 4: drain the free list, refill, then fill the tags
        for (int k = 0; k < 20; k++) begin
            step(rand_group(1'b0, 1'b1), '0, '0);
        end
        for (int k = 0; k < 12; k++) begin
            step('0, take_commits(2), '0);
        end
        for (int k = 0; k < 5; k++) begin
            step(rand_group(1'b1, 1'b1), '0, '0);
        end
        step(rand_group(1'b0, 1'b1), '0, '0);
        finish_test("stall and drop");

        // 5: squash the oldest branch, commits around it stay free
        step('0, take_commits(2), mk_resolve(1'b1));
        step(rand_group(1'b0, 1'b1), take_commits(2), '0);
        for (int k = 0; k < 3; k++) begin
            step(rand_group(1'b0, 1'b1), '0, '0);
        end
        finish_test("mispredict restore");

        // 6: retire frees a tag, then a random mix
        for (int k = 0; k < 4; k++) begin
            step(rand_group(1'b1, 1'b1), take_commits(1), '0);
        end
        step('0, '0, mk_resolve(1'b0));
        step(rand_group(1'b1, 1'b1), '0, '0);
        step(rand_group(1'b1, 1'b1), '0, '0);
        for (int k = 0; k < RAND_CYCLES; k++) begin
            g = rand_group($urandom_range(3, 0) == 0, 1'b0);
            g.valid = ($urandom_range(3, 0) != 0);
            r = '0;
            // one resolve in flight at a time
            if (!squash_pend && !retire_pend && ckpt_q.size() > 0 &&
                $urandom_range(2, 0) == 0) begin
                r = mk_resolve($urandom_range(3, 0) == 0);
            end
            step(g, take_commits($urandom_range(2, 0)), r);
        end
        finish_test("resolve and random mix");

        @(negedge clock);
        #1;
        // every expected response has been compared by now
        assert (due_q.size() == 0) else begin
            $display("some expected responses were never compared with the DUT");
            errors++;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rename_stage.f */
+incdir+hdl
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/checkpoint_bank.sv
hdl/branch_tag_alloc.sv
hdl/rename_stage.sv
sim/rename_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the rename stage testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
mkdir -p build
rm -f build/sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_stage_tb -Mdir build -f rename_stage.f \
    && ./build/Vrename_stage_tb > build/sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat build/sim.log 2>/dev/null; exit 1; }

cat build/sim.log
grep -q "All tests passed" build/sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }
